// ==== design/apb_regs.sv ====
/*
 * APB register block
 *  - control: enable and mute of the other source
 *  - phase period with lower clamp
 *  - sticky clip flag, write 1 to clear
 *  - 16-bit wrapping output sample counter
 */
module apb_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  interp_pkg::apb_req_t apb_req,
	input  logic                 clip,
	input  logic                 sample_valid,
	output interp_pkg::apb_rsp_t apb_rsp,
	output logic                 enable,
	output logic                 mute_other,
	output logic [7:0]           period
);

	interp_pkg::reg_addr_e addr; // Decoded address
	logic                  access; // Access phase
	logic                  wr_en;
	logic                  clip_flag; // Sticky
	logic                  clip_clear;
	logic [15:0]           count;
	logic [7:0]            wr_period; // Clamped write value

	assign addr       = interp_pkg::reg_addr_e'(apb_req.paddr);
	assign access     = apb_req.psel & apb_req.penable;
	assign wr_en      = access & apb_req.pwrite;
	assign clip_clear = wr_en && (addr == interp_pkg::REG_STATUS) && apb_req.pwdata[0];
	assign wr_period  = (apb_req.pwdata[7:0] < 8'(interp_pkg::MIN_PERIOD)) ?
		8'(interp_pkg::MIN_PERIOD) : apb_req.pwdata[7:0];

	// ================================================
	// Register writes
	// ================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			enable     <= 1'b0;
			mute_other <= 1'b0;
			period     <= 8'(interp_pkg::DEFAULT_PERIOD);
			clip_flag  <= 1'b0;
			count      <= 16'd0;
		end else begin
			if (wr_en && addr == interp_pkg::REG_CTRL) begin
				enable     <= apb_req.pwdata[0];
				mute_other <= apb_req.pwdata[1];
			end
			if (wr_en && addr == interp_pkg::REG_PERIOD)
				period <= wr_period; // Never below MIN_PERIOD
			if (clip)
				clip_flag <= 1'b1; // New clip wins over clear
			else if (clip_clear)
				clip_flag <= 1'b0;
			if (sample_valid)
				count <= count + 16'd1; // Wraps at 64k
		end
	end

	// ================================================
	// Read data and error response
	// ================================================
	always_comb begin
		apb_rsp         = '0;
		apb_rsp.pready  = 1'b1; // Zero wait states
		case (addr)
			interp_pkg::REG_CTRL:   apb_rsp.prdata = {30'd0, mute_other, enable};
			interp_pkg::REG_PERIOD: apb_rsp.prdata = {24'd0, period};
			interp_pkg::REG_STATUS: apb_rsp.prdata = {31'd0, clip_flag};
			interp_pkg::REG_COUNT: begin
				apb_rsp.prdata  = {16'd0, count};
				apb_rsp.pslverr = wr_en; // Read only
			end
			default:                apb_rsp.pslverr = access; // Unmapped
		endcase
	end

	// Host must select before enabling
	a_penable_psel: assert property (
		@(posedge clk) disable iff (rst)
		apb_req.penable |-> apb_req.psel
	);

endmodule

// ==== design/audio_interp_top.sv ====
/*
 * Stereo audio interpolator, top level
 *  - APB register block
 *  - four-phase sequencer
 *  - stereo FIR filter
 */
module audio_interp_top #(
	parameter int FIR_TAPS_USED = interp_pkg::FIR_TAPS
) (
	input  logic                 clk,
	input  logic                 rst,
	input  interp_pkg::apb_req_t apb_req,
	input  interp_pkg::stereo_t  main_in,
	input  interp_pkg::stereo_t  other_in,
	output interp_pkg::apb_rsp_t apb_rsp,
	output interp_pkg::stereo_t  sample_out,
	output logic                 sample_valid
);

	logic                enable;
	logic                mute_other;
	logic [7:0]          period;
	interp_pkg::stereo_t fir_in; // Zero-stuffed stream
	logic                fir_strobe;
	logic                clip; // Per-sample clamp pulse

	apb_regs u_regs (
		.clk          (clk),
		.rst          (rst),
		.apb_req      (apb_req),
		.clip         (clip),
		.sample_valid (sample_valid),
		.apb_rsp      (apb_rsp),
		.enable       (enable),
		.mute_other   (mute_other),
		.period       (period)
	);

	interp_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.enable     (enable),
		.mute_other (mute_other),
		.period     (period),
		.main_in    (main_in),
		.other_in   (other_in),
		.fir_in     (fir_in),
		.fir_strobe (fir_strobe)
	);

	fir_stereo #(
		.FIR_TAPS_USED (FIR_TAPS_USED)
	) u_fir (
		.clk          (clk),
		.rst          (rst),
		.fir_strobe   (fir_strobe),
		.fir_in       (fir_in),
		.sample_out   (sample_out),
		.sample_valid (sample_valid),
		.clip         (clip)
	);

endmodule

// ==== design/fir_stereo.sv ====
/*
 * Stereo FIR low-pass filter
 *  - delay line of stereo samples, shifted at each input strobe
 *  - one shared multiply-accumulate per channel, one tap per cycle
 *  - output shift, saturation to 12 bits and clip pulse
 */
module fir_stereo #(
	parameter int FIR_TAPS_USED = interp_pkg::FIR_TAPS
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                fir_strobe,
	input  interp_pkg::stereo_t fir_in,
	output interp_pkg::stereo_t sample_out,
	output logic                sample_valid,
	output logic                clip
);

	localparam int SW    = interp_pkg::SAMPLE_W;
	localparam int ACC_W = SW + 8; // Headroom for coefficient sum
	localparam int IDX_W = (FIR_TAPS_USED > 1) ? $clog2(FIR_TAPS_USED) : 1;
	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((2 ** (SW - 1)) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(-(2 ** (SW - 1)));

	interp_pkg::stereo_t      dly [FIR_TAPS_USED]; // Newest sample at index 0
	logic [IDX_W-1:0]         idx; // Tap being accumulated
	logic                     busy; // MAC running
	logic                     fin; // Shift and saturate stage
	logic signed [ACC_W-1:0]  acc_l;
	logic signed [ACC_W-1:0]  acc_r;
	logic signed [ACC_W-1:0]  coef;
	logic signed [ACC_W-1:0]  prod_l;
	logic signed [ACC_W-1:0]  prod_r;
	logic [SW:0]              sat_l; // {clip, value}
	logic [SW:0]              sat_r;

	// Scale and clamp, top bit flags a clamp
	function automatic logic [SW:0] saturate(input logic signed [ACC_W-1:0] acc);
		logic signed [ACC_W-1:0] shr;
		shr = acc >>> interp_pkg::COEF_SHIFT;
		if (shr > SAT_MAX)
			return {1'b1, SAT_MAX[SW-1:0]};
		if (shr < SAT_MIN)
			return {1'b1, SAT_MIN[SW-1:0]};
		return {1'b0, shr[SW-1:0]};
	endfunction

	// ================================================
	// Shared multiplier per channel
	// ================================================
	assign coef   = ACC_W'(interp_pkg::FIR_COEF[idx]); // Fixed coefficient for this tap
	assign prod_l = ACC_W'($signed(dly[idx].left)) * coef;
	assign prod_r = ACC_W'($signed(dly[idx].right)) * coef;
	assign sat_l  = saturate(acc_l);
	assign sat_r  = saturate(acc_r);

	// ================================================
	// Control and delay line
	// ================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < FIR_TAPS_USED; i++)
				dly[i] <= '0; // Start from silence
			idx          <= '0;
			busy         <= 1'b0;
			fin          <= 1'b0;
			sample_valid <= 1'b0;
			clip         <= 1'b0;
		end else begin
			sample_valid <= 1'b0; // Single-cycle strobes
			clip         <= 1'b0;
			if (fir_strobe) begin
				dly[0] <= fir_in; // Shift in new sample
				for (int i = 1; i < FIR_TAPS_USED; i++)
					dly[i] <= dly[i-1];
				idx  <= '0;
				busy <= 1'b1;
			end else if (busy) begin
				if (idx == IDX_W'(FIR_TAPS_USED - 1)) begin
					busy <= 1'b0; // Last tap
					fin  <= 1'b1;
					idx  <= '0;
				end else begin
					idx <= idx + 1'b1;
				end
			end else if (fin) begin
				fin          <= 1'b0;
				sample_valid <= 1'b1; // Result ready
				clip         <= sat_l[SW] | sat_r[SW]; // Either channel clamped
			end
		end
	end

	// ================================================
	// Accumulators and output samples
	// ================================================
	always_ff @(posedge clk) begin
		if (fir_strobe) begin
			acc_l <= '0; // New sum per strobe
			acc_r <= '0;
		end else if (busy) begin
			acc_l <= acc_l + prod_l;
			acc_r <= acc_r + prod_r;
		end
		if (fin) begin
			sample_out.left  <= sat_l[SW-1:0]; // Held until next result
			sample_out.right <= sat_r[SW-1:0];
		end
	end

	// Period clamp upstream must leave room for the whole MAC
	a_no_strobe_busy: assert property (
		@(posedge clk) disable iff (rst)
		fir_strobe |-> !(busy || fin)
	);

endmodule

// ==== design/interp_pkg.sv ====
/*
 * Shared definitions for the stereo audio interpolator
 *  - sample width and stereo sample struct
 *  - sequencer phase enum
 *  - APB request / response structs and register map
 *  - fixed FIR constants and period limits
 */
package interp_pkg;

	// ================================================
	// Audio samples
	// ================================================
	localparam int SAMPLE_W = 12; // Bits per channel

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] left; // Left channel
		logic signed [SAMPLE_W-1:0] right; // Right channel
	} stereo_t;

	// Four-phase zero-stuffing order
	typedef enum logic [1:0] {
		PH_MAIN   = 2'd0, // FM sample
		PH_ZERO_A = 2'd1, // Stuffed zero
		PH_OTHER  = 2'd2, // PSG or similar
		PH_ZERO_B = 2'd3 // Stuffed zero
	} phase_e;

	// ================================================
	// APB configuration bus
	// ================================================
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready; // Tied high, no wait states
		logic        pslverr;
	} apb_rsp_t;

	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00, // [0] enable, [1] mute_other
		REG_PERIOD = 8'h04, // Cycles per phase minus one
		REG_STATUS = 8'h08, // [0] clip, write 1 to clear
		REG_COUNT  = 8'h0C // Output sample count, read only
	} reg_addr_e;

	// ================================================
	// Filter constants
	// ================================================
	localparam int FIR_TAPS = 8;
	localparam int FIR_COEF [FIR_TAPS] = '{1, 3, 6, 6, 6, 6, 3, 1}; // Symmetric low-pass
	localparam int COEF_SHIFT = 3; // Unity DC gain per zero-stuffed pair
	localparam int MIN_PERIOD = FIR_TAPS + 3; // Filter must finish inside one phase
	localparam int DEFAULT_PERIOD = 41; // 42-cycle phase

endpackage

// ==== design/interp_sequencer.sv ====
/*
 * Phase sequencer
 *  - phase counter producing one strobe per period+1 cycles
 *  - four-phase state: main, zero, other, zero
 *  - source select with optional mute of the other source
 */
module interp_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                enable,
	input  logic                mute_other,
	input  logic [7:0]          period,
	input  interp_pkg::stereo_t main_in,
	input  interp_pkg::stereo_t other_in,
	output interp_pkg::stereo_t fir_in,
	output logic                fir_strobe
);

	logic [7:0]         cnt; // Cycle count inside a phase
	interp_pkg::phase_e phase; // Phase presented on fir_in

	// ================================================
	// Phase counter and state
	// ================================================
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			cnt        <= 8'd0; // Held while disabled
			phase      <= interp_pkg::PH_MAIN;
			fir_strobe <= 1'b0;
		end else begin
			if (cnt == period) begin
				cnt        <= 8'd0; // Wrap
				fir_strobe <= 1'b1;
			end else begin
				cnt        <= cnt + 8'd1;
				fir_strobe <= 1'b0;
			end
			// Filter takes this phase at the strobe edge, then move on
			if (fir_strobe)
				phase <= interp_pkg::phase_e'(phase + 2'd1);
		end
	end

	// ================================================
	// Source select, zero-stuffing
	// ================================================
	always_comb begin
		case (phase)
			interp_pkg::PH_MAIN:  fir_in = main_in;
			interp_pkg::PH_OTHER: fir_in = mute_other ? '0 : other_in; // Muted gives silence
			default:              fir_in = '0; // Both stuffed zeros
		endcase
	end

	// One strobe per phase, never back to back
	a_strobe_single: assert property (
		@(posedge clk) disable iff (rst)
		fir_strobe |=> !fir_strobe
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the audio interpolator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f \
	--top-module tb_audio_interp \
	-o sim_audio_interp

# Keep the output even when the simulation exits with an error
out=$(./obj_dir/sim_audio_interp 2>&1) || true
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
	echo "run.sh: simulation passed"
else
	echo "run.sh: simulation did not pass"
	exit 1
fi

// ==== src.f ====
design/interp_pkg.sv
design/interp_sequencer.sv
design/fir_stereo.sv
design/apb_regs.sv
design/audio_interp_top.sv
test/tb_audio_interp.sv

// ==== test/tb_audio_interp.sv ====
/*
 * Testbench for the stereo audio interpolator
 *  - clock, reset, APB and value check tasks
 *  - reference FIR model over the zero-stuffed stream
 *  - directed tests: reset, registers, impulse, mixing, saturation, count
 */
module tb_audio_interp;

	localparam int SW       = interp_pkg::SAMPLE_W;
	localparam int SMAX     = (1 << (SW - 1)) - 1; // Full scale positive
	localparam int SMIN     = -(1 << (SW - 1)); // Full scale negative
	localparam int WAIT_MAX = 1000; // Cycles allowed per output sample

	logic                 clk;
	logic                 rst;
	interp_pkg::apb_req_t apb_req;
	interp_pkg::apb_rsp_t apb_rsp;
	interp_pkg::stereo_t  main_in;
	interp_pkg::stereo_t  other_in;
	interp_pkg::stereo_t  sample_out;
	logic                 sample_valid;

	int seed = 32'h93c7_ad03;
	int hist_l[$]; // Expected filter input, one entry per strobe
	int hist_r[$];
	int out_count; // Outputs seen since reset
	bit muted; // Mute state live at the next strobe

	audio_interp_top UUT (
		.clk          (clk),
		.rst          (rst),
		.apb_req      (apb_req),
		.main_in      (main_in),
		.other_in     (other_in),
		.apb_rsp      (apb_rsp),
		.sample_out   (sample_out),
		.sample_valid (sample_valid)
	);

	always #5 clk = ~clk; // 10 unit period

	// ================================================
	// Checks and waits
	// ================================================
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_stop($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		@(negedge clk); // Step past the previous pulse
		while (!sample_valid) begin
			if (n == WAIT_MAX)
				fail_stop("timed out waiting for sample_valid");
			n++;
			@(negedge clk);
		end
	endtask

	task automatic expect_quiet(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (sample_valid)
				fail_stop("sample_valid seen while the interpolator should be idle");
		end
	endtask

	// ================================================
	// APB host
	// ================================================
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk);
		apb_req.psel    = 1'b1; // Setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(negedge clk);
		apb_req.penable = 1'b1; // Access, completes at next edge
		#2;
		err = apb_rsp.pslverr;
		check_eq("pready", 32'(apb_rsp.pready), 32'd1); // No wait states
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#2; // Mid low phase, read data settled
		data = apb_rsp.prdata;
		err  = apb_rsp.pslverr;
		check_eq("pready", 32'(apb_rsp.pready), 32'd1);
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input int exp_err);
		logic err;
		apb_write(addr, data, err);
		check_eq("pslverr", 32'(err), exp_err);
	endtask

	task automatic reg_read(input logic [7:0] addr, input string name, input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		apb_read(addr, rd, err);
		check_eq(name, rd, exp);
		check_eq("pslverr", 32'(err), 32'd0);
	endtask

	// ================================================
	// Reference model and stream driver
	// ================================================
	function automatic int sat_shift(input int acc);
		int v;
		v = acc >>> interp_pkg::COEF_SHIFT;
		if (v > SMAX)
			return SMAX;
		if (v < SMIN)
			return SMIN;
		return v;
	endfunction

	task automatic model_output(input int n, output int exp_l, output int exp_r);
		int acc_l;
		int acc_r;
		int i;
		acc_l = 0;
		acc_r = 0;
		for (i = 0; i < interp_pkg::FIR_TAPS; i++) begin
			if (n >= i) begin
				acc_l += interp_pkg::FIR_COEF[i] * hist_l[n - i]; // Newest on tap 0
				acc_r += interp_pkg::FIR_COEF[i] * hist_r[n - i];
			end
		end
		exp_l = sat_shift(acc_l);
		exp_r = sat_shift(acc_r);
	endtask

	function automatic interp_pkg::stereo_t make_stereo(input int l, input int r);
		interp_pkg::stereo_t s;
		s.left  = SW'(l);
		s.right = SW'(r);
		return s;
	endfunction

	function automatic int rand_sample();
		return $random(seed) % 1024; // Sum of 16 stays below full scale
	endfunction

	// Hold sources for the next strobe, then check the resulting output
	task automatic feed_sample(input int main_l, input int main_r, input int oth_l,
			input int oth_r);
		int ph;
		int xl;
		int xr;
		int el;
		int er;
		main_in  = make_stereo(main_l, main_r);
		other_in = make_stereo(oth_l, oth_r);
		ph = out_count % 4; // 0 main, 1 zero, 2 other, 3 zero
		xl = 0;
		xr = 0;
		if (ph == 0) begin
			xl = main_l;
			xr = main_r;
		end else if (ph == 2 && !muted) begin
			xl = oth_l;
			xr = oth_r;
		end
		hist_l.push_back(xl);
		hist_r.push_back(xr);
		wait_valid();
		model_output(out_count, el, er);
		check_eq("sample_out.left", 32'($signed(sample_out.left)), el);
		check_eq("sample_out.right", 32'($signed(sample_out.right)), er);
		out_count++;
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic test_reset_values();
		reg_read(interp_pkg::REG_CTRL, "REG_CTRL", 32'd0);
		reg_read(interp_pkg::REG_PERIOD, "REG_PERIOD", interp_pkg::DEFAULT_PERIOD);
		reg_read(interp_pkg::REG_STATUS, "REG_STATUS", 32'd0);
		reg_read(interp_pkg::REG_COUNT, "REG_COUNT", 32'd0);
		expect_quiet(200); // Still disabled
	endtask

	task automatic test_registers();
		logic [31:0] rd;
		logic        err;
		reg_write(interp_pkg::REG_CTRL, 32'h2, 0); // Mute only
		reg_read(interp_pkg::REG_CTRL, "REG_CTRL", 32'h2);
		reg_write(interp_pkg::REG_CTRL, 32'h0, 0);
		reg_read(interp_pkg::REG_CTRL, "REG_CTRL", 32'h0);
		reg_write(interp_pkg::REG_PERIOD, 32'd5, 0); // Below the clamp
		reg_read(interp_pkg::REG_PERIOD, "REG_PERIOD", interp_pkg::MIN_PERIOD);
		reg_write(interp_pkg::REG_PERIOD, 32'd20, 0);
		reg_read(interp_pkg::REG_PERIOD, "REG_PERIOD", 32'd20);
		apb_read(8'h10, rd, err); // Unmapped
		check_eq("pslverr", 32'(err), 32'd1);
		reg_write(8'h10, 32'h1, 1);
		reg_write(interp_pkg::REG_COUNT, 32'h55, 1); // Read only
		reg_read(interp_pkg::REG_COUNT, "REG_COUNT", 32'd0);
	endtask

	task automatic test_impulse();
		int n;
		reg_write(interp_pkg::REG_CTRL, 32'h1, 0); // Enable, other source silent
		reg_read(interp_pkg::REG_CTRL, "REG_CTRL", 32'h1);
		for (n = 0; n < 12; n++) begin
			if (n == 0)
				feed_sample(80, -160, 0, 0);
			else
				feed_sample(0, 0, 0, 0);
			if (n < interp_pkg::FIR_TAPS) begin
				// 80 >>> 3 and -160 >>> 3 scale each tap exactly
				check_eq("impulse left", 32'($signed(sample_out.left)),
					10 * interp_pkg::FIR_COEF[n]);
				check_eq("impulse right", 32'($signed(sample_out.right)),
					-20 * interp_pkg::FIR_COEF[n]);
			end
		end
	endtask

	task automatic test_mixing();
		int n;
		int ml;
		int mr;
		int ol;
		int orr_val;
		for (n = 0; n < 32; n++) begin
			if (n == 16) begin
				reg_write(interp_pkg::REG_CTRL, 32'h3, 0); // Mute other source
				muted = 1'b1;
			end
			ml      = rand_sample();
			mr      = rand_sample();
			ol      = rand_sample();
			orr_val = rand_sample();
			feed_sample(ml, mr, ol, orr_val);
		end
		reg_write(interp_pkg::REG_CTRL, 32'h1, 0);
		muted = 1'b0;
	endtask

	task automatic test_saturation();
		int n;
		for (n = 0; n < 12; n++)
			feed_sample(SMAX, SMAX, SMAX, SMAX);
		check_eq("clamp left", 32'($signed(sample_out.left)), SMAX);
		check_eq("clamp right", 32'($signed(sample_out.right)), SMAX);
		reg_read(interp_pkg::REG_STATUS, "REG_STATUS", 32'd1);
		for (n = 0; n < 12; n++)
			feed_sample(SMIN, SMIN, SMIN, SMIN);
		check_eq("clamp left", 32'($signed(sample_out.left)), SMIN);
		check_eq("clamp right", 32'($signed(sample_out.right)), SMIN);
		for (n = 0; n < 12; n++)
			feed_sample(0, 0, 0, 0); // Flush the delay line
		reg_write(interp_pkg::REG_STATUS, 32'h1, 0); // Write 1 to clear
		reg_read(interp_pkg::REG_STATUS, "REG_STATUS", 32'd0);
	endtask

	task automatic test_count_disable();
		feed_sample(0, 0, 0, 0); // Disable lands just after an output, before the next strobe
		reg_read(interp_pkg::REG_COUNT, "REG_COUNT", out_count);
		reg_write(interp_pkg::REG_CTRL, 32'h0, 0);
		expect_quiet(200);
		reg_read(interp_pkg::REG_COUNT, "REG_COUNT", out_count);
	endtask

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		apb_req   = '0;
		main_in   = '0;
		other_in  = '0;
		out_count = 0;
		muted     = 1'b0;
		repeat (8) @(negedge clk); // 8 reset cycles
		rst = 1'b0;
		test_reset_values();
		test_registers();
		test_impulse();
		test_mixing();
		test_saturation();
		test_count_disable();
		$display("*** PASSED ***");
		$finish;
	end

endmodule
